// ==== Makefile ====
# Verilator build for the Mac keyboard converter

VERILATOR  ?= verilator
TOP        ?= macKbdTb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The run fails unless the simulation prints the pass message
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== files.f ====
+incdir+verif
hw/macKbdPkg.sv
hw/keymapRom.sv
hw/paceTimer.sv
hw/commandLatch.sv
hw/keyCapture.sv
hw/replyEngine.sv
hw/macKbd.sv
verif/macKbdTb.sv

// ==== hw/commandLatch.sv ====
`timescale 1ns/1ps

module commandLatch import macKbdPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     ce,
    input  macByte_t hostCmd,
    input  logic     hostStrobe,
    output hostCmd_t cmd
);
    hostCmd_t cmdDecoded;

    always_comb begin
        case (hostCmd)
            CmdByteInquiry: cmdDecoded = CmdInquiry;
            CmdByteInstant: cmdDecoded = CmdInstant;
            CmdByteModel:   cmdDecoded = CmdModel;
            CmdByteTest:    cmdDecoded = CmdTest;
            default:        cmdDecoded = CmdNone;  // Unknown byte
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmd <= CmdNone;
        end else if (ce && hostStrobe) begin
            cmd <= cmdDecoded;
        end
    end

    // Held command feeds both the capture and reply logic
    cmdHeld: assert property (@(posedge clk) disable iff (reset)
        !(ce && hostStrobe) |=> $stable(cmd))
        else $error("command changed without a host strobe");

endmodule

// ==== hw/keyCapture.sv ====
`timescale 1ns/1ps

module keyCapture import macKbdPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     ce,
    input  ps2Key_t  ps2Key,
    input  macCode_t macCode,
    input  hostCmd_t cmd,
    input  logic     popKey,
    output logic     keyPending,
    output macCode_t pendingCode,
    output logic     capsLock
);
    ps2Key_t keyQ;  // Lines up with the ROM output
    logic    prevToggle;
    logic    newEvent;
    logic    isCaps;
    logic    flush;
    logic    eventTaken;
    logic    capture;
    logic    clearPrefix;

    assign newEvent = keyQ.toggle != prevToggle;
    assign isCaps   = {keyQ.extended, keyQ.code} == CapsLockCode;
    assign flush    = (cmd == CmdModel) || (cmd == CmdTest);

    // Caps lock events are dropped while caps lock is on
    assign eventTaken  = newEvent && !(isCaps && capsLock) && !popKey && !flush;
    assign capture     = eventTaken && !keyPending;
    assign clearPrefix = popKey && keyPending && pendingCode[8] && !flush;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            keyQ       <= '0;
            prevToggle <= 1'b0;
        end else if (ce) begin
            keyQ       <= ps2Key;
            prevToggle <= keyQ.toggle;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            keyPending <= 1'b0;
            capsLock   <= 1'b0;
        end else if (ce) begin
            if (flush) begin
                keyPending <= 1'b0;
            end else if (popKey && !pendingCode[8]) begin
                keyPending <= 1'b0;  // Last byte of the key sent
            end else if (capture) begin
                keyPending <= 1'b1;
            end
            if (eventTaken && isCaps && !keyQ.released) begin
                capsLock <= ~capsLock;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ce) begin
            if (capture) begin
                pendingCode <= {macCode[8], keyQ.released, macCode[6:0]};
            end else if (clearPrefix) begin
                pendingCode[8] <= 1'b0;  // Prefix sent, code goes next
            end
        end
    end

    // Only the prefix flag may change under a held key, and only downward
    pendingStable: assert property (@(posedge clk) disable iff (reset)
        keyPending && $past(keyPending) |->
            pendingCode[7:0] == $past(pendingCode[7:0]) &&
            !(pendingCode[8] && !$past(pendingCode[8])))
        else $error("pending key changed while held");

endmodule

// ==== hw/keymapRom.sv ====
`timescale 1ns/1ps

module keymapRom import macKbdPkg::*; (
    input  logic     clk,
    input  ps2Code_t addr,
    output macCode_t macCode
);
    ps2Code_t addrQ;

    always_ff @(posedge clk) begin
        addrQ <= addr;
    end

    always_comb begin
        case (addrQ)
            9'h00D: macCode = 9'h061;
            9'h00E: macCode = 9'h065;
            9'h011: macCode = 9'h06f;
            9'h012: macCode = 9'h071;
            9'h015: macCode = 9'h019;
            9'h016: macCode = 9'h025;
            9'h018: macCode = 9'h019;
            9'h019: macCode = 9'h025;
            9'h01A: macCode = 9'h00d;
            9'h01B: macCode = 9'h003;
            9'h01C: macCode = 9'h001;
            9'h01D: macCode = 9'h01b;
            9'h01E: macCode = 9'h027;
            9'h021: macCode = 9'h011;
            9'h022: macCode = 9'h00f;
            9'h023: macCode = 9'h005;
            9'h024: macCode = 9'h01d;
            9'h025: macCode = 9'h02b;
            9'h026: macCode = 9'h029;
            9'h029: macCode = 9'h063;
            9'h02A: macCode = 9'h013;
            9'h02B: macCode = 9'h007;
            9'h02C: macCode = 9'h023;
            9'h02D: macCode = 9'h01f;
            9'h02E: macCode = 9'h02f;
            9'h031: macCode = 9'h05b;
            9'h032: macCode = 9'h017;
            9'h033: macCode = 9'h009;
            9'h034: macCode = 9'h00b;
            9'h035: macCode = 9'h021;
            9'h036: macCode = 9'h02d;
            9'h03A: macCode = 9'h05d;
            9'h03B: macCode = 9'h04d;
            9'h03C: macCode = 9'h041;
            9'h03D: macCode = 9'h035;
            9'h03E: macCode = 9'h039;
            9'h041: macCode = 9'h057;
            9'h042: macCode = 9'h051;
            9'h043: macCode = 9'h045;
            9'h044: macCode = 9'h03f;
            9'h045: macCode = 9'h03b;
            9'h046: macCode = 9'h033;
            9'h049: macCode = 9'h05f;
            9'h04A: macCode = 9'h059;
            9'h04B: macCode = 9'h04b;
            9'h04C: macCode = 9'h053;
            9'h04D: macCode = 9'h047;
            9'h04E: macCode = 9'h037;
            9'h052: macCode = 9'h04f;
            9'h054: macCode = 9'h043;
            9'h055: macCode = 9'h031;
            9'h058: macCode = 9'h073;
            9'h059: macCode = 9'h071;
            9'h05A: macCode = 9'h049;
            9'h05B: macCode = 9'h03d;
            9'h05D: macCode = 9'h055;
            9'h061: macCode = 9'h071;
            9'h066: macCode = 9'h067;
            // Numeric keypad, sent with the prefix byte
            9'h069: macCode = 9'h127;
            9'h06B: macCode = 9'h12d;
            9'h06C: macCode = 9'h133;
            9'h070: macCode = 9'h125;
            9'h071: macCode = 9'h103;
            9'h072: macCode = 9'h129;
            9'h073: macCode = 9'h12f;
            9'h074: macCode = 9'h131;
            9'h075: macCode = 9'h137;
            9'h079: macCode = 9'h10d;
            9'h07A: macCode = 9'h12b;
            9'h07B: macCode = 9'h11d;
            9'h07C: macCode = 9'h105;
            9'h07D: macCode = 9'h139;
            9'h111: macCode = 9'h06f;
            9'h11F: macCode = 9'h075;
            9'h14A: macCode = 9'h11b;
            9'h15A: macCode = 9'h119;
            9'h16B: macCode = 9'h10d;  // Arrows go out as keypad codes
            9'h171: macCode = 9'h10f;
            9'h172: macCode = 9'h111;
            9'h174: macCode = 9'h105;
            9'h175: macCode = 9'h11b;
            default: macCode = {1'b0, ReplyNull};
        endcase
    end

endmodule

// ==== hw/macKbd.sv ====
`timescale 1ns/1ps

module macKbd import macKbdPkg::*; #(
    parameter int PaceWidth  = DefaultPaceWidth,
    parameter int ShortCount = DefaultShortCount
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     ce,
    input  macByte_t hostCmd,
    input  logic     hostStrobe,
    input  ps2Key_t  ps2Key,
    output macByte_t reply,
    output logic     replyStrobe,
    output logic     capsLock
);
    hostCmd_t cmd;
    logic     tickShort;
    logic     tickLong;
    macCode_t macCode;
    logic     keyPending;
    macCode_t pendingCode;
    logic     popKey;

    commandLatch u_commandLatch (
        .clk(clk),
        .reset(reset),
        .ce(ce),
        .hostCmd(hostCmd),
        .hostStrobe(hostStrobe),
        .cmd(cmd)
    );

    paceTimer #(
        .PaceWidth(PaceWidth),
        .ShortCount(ShortCount)
    ) u_paceTimer (
        .clk(clk),
        .reset(reset),
        .ce(ce),
        .hostStrobe(hostStrobe),
        .tickShort(tickShort),
        .tickLong(tickLong)
    );

    keymapRom u_keymapRom (
        .clk(clk),
        .addr({ps2Key.extended, ps2Key.code}),
        .macCode(macCode)
    );

    keyCapture u_keyCapture (
        .clk(clk),
        .reset(reset),
        .ce(ce),
        .ps2Key(ps2Key),
        .macCode(macCode),
        .cmd(cmd),
        .popKey(popKey),
        .keyPending(keyPending),
        .pendingCode(pendingCode),
        .capsLock(capsLock)
    );

    replyEngine u_replyEngine (
        .clk(clk),
        .reset(reset),
        .ce(ce),
        .cmd(cmd),
        .tickShort(tickShort),
        .tickLong(tickLong),
        .hostStrobe(hostStrobe),
        .keyPending(keyPending),
        .pendingCode(pendingCode),
        .popKey(popKey),
        .reply(reply),
        .replyStrobe(replyStrobe)
    );

endmodule

// ==== hw/macKbdPkg.sv ====
package macKbdPkg;

    // Defaults for the top-level parameters
    localparam int DefaultPaceWidth  = 22;
    localparam int DefaultShortCount = 4095;

    typedef logic [7:0] macByte_t;
    typedef logic [8:0] ps2Code_t;  // Extended flag on top
    typedef logic [8:0] macCode_t;  // Bit 8 keypad prefix, bits 6..0 key code

    typedef struct packed {
        logic       toggle;    // Flips on every new event
        logic       released;
        logic       extended;
        logic [7:0] code;
    } ps2Key_t;

    typedef enum logic [2:0] {
        CmdNone,
        CmdInquiry,
        CmdInstant,
        CmdModel,
        CmdTest
    } hostCmd_t;

    // Host command bytes
    localparam macByte_t CmdByteInquiry = 8'h10;
    localparam macByte_t CmdByteInstant = 8'h14;
    localparam macByte_t CmdByteModel   = 8'h16;
    localparam macByte_t CmdByteTest    = 8'h36;

    // Reply bytes
    localparam macByte_t ReplyTest   = 8'h7d;
    localparam macByte_t ReplyModel  = 8'h03;
    localparam macByte_t ReplyNull   = 8'h7b;
    localparam macByte_t ReplyKeypad = 8'h79;

    localparam ps2Code_t CapsLockCode = 9'h058;

endpackage

// ==== hw/paceTimer.sv ====
`timescale 1ns/1ps

module paceTimer import macKbdPkg::*; #(
    parameter int PaceWidth  = DefaultPaceWidth,
    parameter int ShortCount = DefaultShortCount
) (
    input  logic clk,
    input  logic reset,
    input  logic ce,
    input  logic hostStrobe,
    output logic tickShort,
    output logic tickLong
);
    logic [PaceWidth-1:0] paceCount;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            paceCount <= '0;
        end else if (ce) begin
            if (hostStrobe) begin
                paceCount <= '0;  // Restart on every host command
            end else if (!tickLong) begin
                paceCount <= paceCount + 1'b1;
            end
        end
    end

    assign tickShort = paceCount == PaceWidth'(ShortCount);
    assign tickLong  = &paceCount;  // Saturated

    initial begin
        assert (ShortCount < (2 ** PaceWidth) - 1)
            else $error("ShortCount does not fit below the long tick");
    end

endmodule

// ==== hw/replyEngine.sv ====
`timescale 1ns/1ps

module replyEngine import macKbdPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     ce,
    input  hostCmd_t cmd,
    input  logic     tickShort,
    input  logic     tickLong,
    input  logic     hostStrobe,
    input  logic     keyPending,
    input  macCode_t pendingCode,
    output logic     popKey,
    output macByte_t reply,
    output logic     replyStrobe
);
    logic inquiryArmed;
    logic fixedReply;  // Model or test answer

    assign fixedReply = (cmd == CmdModel) || (cmd == CmdTest);

    // Inquiry waits for a key or for the timeout
    assign popKey = ((cmd == CmdInstant) && tickShort) ||
                    (inquiryArmed && (tickLong || keyPending));

    assign replyStrobe = (fixedReply && tickShort) || popKey;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inquiryArmed <= 1'b0;
        end else if (ce) begin
            if (hostStrobe || replyStrobe) begin
                inquiryArmed <= 1'b0;
            end else if (tickShort) begin
                inquiryArmed <= cmd == CmdInquiry;
            end
        end
    end

    always_comb begin
        if (cmd == CmdTest) begin
            reply = ReplyTest;
        end else if (cmd == CmdModel) begin
            reply = ReplyModel;
        end else if (keyPending) begin
            reply = pendingCode[8] ? ReplyKeypad : pendingCode[7:0];
        end else begin
            reply = ReplyNull;
        end
    end

    // Host sees one strobe per reply byte
    singleStrobe: assert property (@(posedge clk) disable iff (reset)
        replyStrobe |=> !replyStrobe)
        else $error("reply strobe held for two cycles");

endmodule

// ==== verif/macKbdTbTasks.svh ====
`ifndef MAC_KBD_TB_TASKS_SVH
`define MAC_KBD_TB_TASKS_SVH

function automatic logic [31:0] nextRandom(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic sendCommand(input macByte_t value);
    @(posedge clk);
    hostCmd    <= value;
    hostStrobe <= 1'b1;
    @(posedge clk);
    hostStrobe <= 1'b0;
endtask

// Flips the toggle bit to mark a new event
task automatic sendKey(input logic released, input ps2Code_t code);
    ps2Key_t keyWord;
    keyWord.toggle   = ~ps2Key.toggle;
    keyWord.released = released;
    keyWord.extended = code[8];
    keyWord.code     = code[7:0];
    @(posedge clk);
    ps2Key <= keyWord;
endtask

// A delay of 0 skips the timing check
task automatic expectReply(input macByte_t value, input int delay);
    expReply   <= value;
    expDelay   <= delay;
    delayCheck <= delay != 0;
    replyOpen  <= 1'b1;
endtask

task automatic waitReply(input int limit);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!replyStrobe && waited < limit) begin
        @(negedge clk);
        waited++;
    end
    if (!replyStrobe) begin
        timeoutErrors++;
        $display("No reply strobe within %0d cycles in test %s", limit, testName);
    end
    @(posedge clk);
    replyOpen  <= 1'b0;
    delayCheck <= 1'b0;
    @(negedge clk);
endtask

task automatic commandReply(input macByte_t cmdByte, input macByte_t value, input int delay);
    expectReply(value, delay);
    sendCommand(cmdByte);
    waitReply(ReplyWait);
endtask

// Keypad entries need a prefix reply before the code
task automatic inquireKey(input macCode_t mac, input logic released);
    if (mac[8]) begin
        commandReply(CmdByteInquiry, ReplyKeypad, ShortDelay + 1);
    end
    commandReply(CmdByteInquiry, {released, mac[6:0]}, ShortDelay + 1);
endtask

task automatic checkCapsLock(input logic expected);
    @(negedge clk);
    assert (capsLock == expected)
        else begin
            valueErrors++;
            $display("ERR %s capsLock expected %0b actual %0b", testName, expected, capsLock);
        end
endtask

`endif

// ==== verif/macKbdTb.sv ====
`timescale 1ns/1ps

module macKbdTb import macKbdPkg::*; ();

    localparam int PaceWidth  = 10;
    localparam int ShortCount = 15;
    localparam int ShortDelay = ShortCount + 1;  // Host strobe to short tick reply
    localparam int LongDelay  = 2 ** PaceWidth;  // Host strobe to inquiry timeout
    localparam int ReplyWait  = LongDelay + 64;
    localparam logic [31:0] Seed = 32'h12455fc1;
    localparam int NumKeys = 8;

    // Scan codes and their table entries for random stimulus
    localparam ps2Code_t KeyScan [NumKeys] = '{
        9'h01C, 9'h01B, 9'h023, 9'h02B, 9'h069, 9'h07A, 9'h16B, 9'h11F
    };
    localparam macCode_t KeyMac [NumKeys] = '{
        9'h001, 9'h003, 9'h005, 9'h007, 9'h127, 9'h12b, 9'h10d, 9'h075
    };

    logic     clk;
    logic     reset;
    logic     ce;
    macByte_t hostCmd;
    logic     hostStrobe;
    ps2Key_t  ps2Key;
    macByte_t reply;
    logic     replyStrobe;
    logic     capsLock;

    string    testName;
    macByte_t expReply;
    int       expDelay;
    logic     delayCheck;
    logic     replyOpen;  // A reply strobe is allowed
    int       cyclesSinceCmd = 0;
    int       valueErrors = 0;
    int       timingErrors = 0;
    int       timeoutErrors = 0;

    `include "macKbdTbTasks.svh"

    macKbd #(
        .PaceWidth(PaceWidth),
        .ShortCount(ShortCount)
    ) u_macKbd (
        .clk(clk),
        .reset(reset),
        .ce(ce),
        .hostCmd(hostCmd),
        .hostStrobe(hostStrobe),
        .ps2Key(ps2Key),
        .reply(reply),
        .replyStrobe(replyStrobe),
        .capsLock(capsLock)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyclesSinceCmd <= hostStrobe ? 1 : cyclesSinceCmd + 1;
    end

    replyValue: assert property (@(posedge clk) disable iff (reset)
        replyStrobe && replyOpen |-> reply == expReply)
        else begin
            valueErrors++;
            $display("ERR %s reply expected %02h actual %02h", testName, expReply,
                $sampled(reply));
        end

    replyWanted: assert property (@(posedge clk) disable iff (reset)
        replyStrobe |-> replyOpen)
        else begin
            timingErrors++;
            $display("Reply strobe seen when none was expected in test %s", testName);
        end

    replyDelay: assert property (@(posedge clk) disable iff (reset)
        replyStrobe && delayCheck |-> cyclesSinceCmd == expDelay)
        else begin
            timingErrors++;
            $display("ERR %s delay expected %0d actual %0d", testName, expDelay,
                $sampled(cyclesSinceCmd));
        end

    initial begin
        logic [31:0] rnd;
        int          idx;
        logic        rel;
        reset      <= 1'b1;
        ce         <= 1'b1;
        hostCmd    <= '0;
        hostStrobe <= 1'b0;
        ps2Key     <= '0;
        expReply   <= '0;
        expDelay   <= 0;
        delayCheck <= 1'b0;
        replyOpen  <= 1'b0;
        testName = "reset";
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (!replyStrobe && !capsLock)
            else begin
                timingErrors++;
                $display("Reply strobe or caps lock not low after reset");
            end

        testName = "model";
        commandReply(CmdByteModel, ReplyModel, ShortDelay);
        repeat (40) @(posedge clk);  // Room for a stray second strobe

        testName = "instant idle";
        commandReply(CmdByteInstant, ReplyNull, ShortDelay);

        testName = "test flush";
        sendKey(1'b0, 9'h01C);
        repeat (3) @(posedge clk);
        commandReply(CmdByteTest, ReplyTest, ShortDelay);
        commandReply(CmdByteInstant, ReplyNull, ShortDelay);

        testName = "inquiry idle";
        commandReply(CmdByteInquiry, ReplyNull, LongDelay);

        testName = "key press";
        sendKey(1'b0, 9'h01C);
        repeat (3) @(posedge clk);
        inquireKey(9'h001, 1'b0);

        testName = "release in inquiry";
        expectReply(8'h81, 0);
        sendCommand(CmdByteInquiry);
        repeat (30) @(posedge clk);
        sendKey(1'b1, 9'h01C);
        waitReply(ReplyWait);

        testName = "lost event";
        sendKey(1'b0, 9'h01B);
        repeat (3) @(posedge clk);
        sendKey(1'b0, 9'h023);  // Dropped while the first key is pending
        repeat (3) @(posedge clk);
        inquireKey(9'h003, 1'b0);
        commandReply(CmdByteInquiry, ReplyNull, LongDelay);

        testName = "keypad";
        sendKey(1'b0, 9'h069);
        repeat (3) @(posedge clk);
        inquireKey(9'h127, 1'b0);
        sendKey(1'b1, 9'h069);
        repeat (3) @(posedge clk);
        inquireKey(9'h127, 1'b1);

        testName = "caps lock";
        sendKey(1'b0, CapsLockCode);
        repeat (3) @(posedge clk);
        checkCapsLock(1'b1);
        inquireKey(9'h073, 1'b0);
        sendKey(1'b1, CapsLockCode);
        repeat (3) @(posedge clk);
        sendKey(1'b0, CapsLockCode);
        repeat (3) @(posedge clk);
        sendKey(1'b1, CapsLockCode);
        repeat (3) @(posedge clk);
        checkCapsLock(1'b1);
        sendKey(1'b0, 9'h01C);
        repeat (3) @(posedge clk);
        inquireKey(9'h001, 1'b0);

        testName = "random";
        rnd = Seed;
        for (int i = 0; i < 16; i++) begin
            rnd = nextRandom(rnd);
            idx = int'(rnd[18:16]);
            rel = rnd[24];
            sendKey(rel, KeyScan[idx]);
            repeat (3) @(posedge clk);
            inquireKey(KeyMac[idx], rel);
        end

        repeat (4) @(posedge clk);
        $display("Errors: value %0d, timing %0d, timeout %0d",
            valueErrors, timingErrors, timeoutErrors);
        if (valueErrors + timingErrors + timeoutErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
